/* Makefile */
VERILATOR ?= verilator
TOP ?= lsq_tb
FILELIST ?= filelist.f
SEED ?= 17316
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)

/* common/lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

  localparam int LSQ_DEPTH = 8;
  localparam int IDX_W = $clog2(LSQ_DEPTH);
  localparam int TAG_W = 6;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } op_kind_e;

  typedef struct packed {
    op_kind_e                      kind;
    logic [TAG_W-1:0]              tag;
    logic [mem_pkg::ADDR_W-1:0]    addr;
    logic [mem_pkg::DATA_W-1:0]    data;
  } dispatch_t;

  typedef struct packed {
    logic [mem_pkg::ADDR_W-1:0]    addr;
    logic [mem_pkg::DATA_W-1:0]    data;
    logic                          committed;
  } store_entry_t;

  // sq_tail is the store queue tail at dispatch, with its wrap bit.
  typedef struct packed {
    logic [TAG_W-1:0]              tag;
    logic [mem_pkg::ADDR_W-1:0]    addr;
    logic                          forwarded;
    logic [mem_pkg::DATA_W-1:0]    fwd_data;
    logic [IDX_W:0]                sq_tail;
  } load_entry_t;

  typedef struct packed {
    logic [TAG_W-1:0]              tag;
    logic [mem_pkg::DATA_W-1:0]    data;
  } load_result_t;

  typedef struct packed {
    logic                          hit;
    logic [mem_pkg::DATA_W-1:0]    data;
  } fwd_t;

endpackage

`default_nettype wire

/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // Word-addressed memory geometry.
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;
  localparam int MEM_DEPTH = 256;

  // One memory access. Reads ignore wdata.
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire

/* filelist.f */
common/mem_pkg.sv
common/lsq_pkg.sv
hw/lsq/store_queue.sv
hw/lsq/load_queue.sv
hw/mem_arbiter.sv
hw/data_memory.sv
hw/lsq_top.sv
sim/lsq_tb.sv

/* hw/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       req_valid,
  input  mem_pkg::mem_req_t          req,
  output logic                       rsp_valid,
  output logic [mem_pkg::DATA_W-1:0] rsp_data
);

  logic [mem_pkg::DATA_W-1:0] words [mem_pkg::MEM_DEPTH];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
        words[i] <= '0;
      end
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= req_valid && !req.write;
      if (req_valid && req.write) begin
        words[req.addr] <= req.wdata;
      end
    end
  end

  // Read data lands one cycle after the grant.
  always_ff @(posedge clock) begin
    if (req_valid && !req.write) begin
      rsp_data <= words[req.addr];
    end
  end

endmodule

`default_nettype wire

/* hw/lsq/load_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module load_queue (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       alloc_valid,
  input  lsq_pkg::load_entry_t       alloc_entry,
  output logic                       full,
  output logic                       barrier_valid,
  output logic [lsq_pkg::IDX_W:0]    barrier_ptr,
  output logic                       mem_req_valid,
  output mem_pkg::mem_req_t          mem_req,
  input  logic                       mem_req_ready,
  input  logic                       rsp_valid,
  input  logic [mem_pkg::DATA_W-1:0] rsp_data,
  output logic                       load_result_valid,
  output lsq_pkg::load_result_t      load_result,
  input  logic                       load_result_ready
);

  lsq_pkg::load_entry_t entries [lsq_pkg::LSQ_DEPTH];

  logic [lsq_pkg::IDX_W:0]   head;
  logic [lsq_pkg::IDX_W:0]   tail;
  logic [lsq_pkg::IDX_W:0]   count;
  logic [lsq_pkg::IDX_W-1:0] head_slot;
  lsq_pkg::load_entry_t      head_entry;
  logic                      outstanding;
  logic                      head_data_valid;
  logic [mem_pkg::DATA_W-1:0] head_data;
  logic                      head_read;
  logic                      pop;

  assign count = tail - head;
  assign full = count == (lsq_pkg::IDX_W + 1)'(lsq_pkg::LSQ_DEPTH);
  assign head_slot = head[lsq_pkg::IDX_W-1:0];
  assign head_entry = entries[head_slot];

  // Head has already read memory, or its data is back.
  assign head_read = outstanding || head_data_valid;

  assign mem_req_valid = count != '0 && !flush && !head_entry.forwarded &&
                         !outstanding && !head_data_valid;
  assign mem_req = '{write: 1'b0, addr: head_entry.addr, wdata: '0};

  assign load_result_valid = count != '0 && (head_entry.forwarded || head_data_valid);
  assign load_result = '{tag:  head_entry.tag,
                         data: head_entry.forwarded ? head_entry.fwd_data : head_data};
  assign pop = load_result_valid && load_result_ready;

  // Oldest load that still has to read memory; scanned young to old.
  always_comb begin
    logic [lsq_pkg::IDX_W:0] offset;
    logic [lsq_pkg::IDX_W:0] pos;
    barrier_valid = 1'b0;
    barrier_ptr = '0;
    for (int i = lsq_pkg::LSQ_DEPTH - 1; i >= 0; i--) begin
      offset = (lsq_pkg::IDX_W + 1)'(i);
      pos = head + offset;
      if (offset < count && !entries[pos[lsq_pkg::IDX_W-1:0]].forwarded &&
          !(offset == '0 && head_read)) begin
        barrier_valid = 1'b1;
        barrier_ptr = entries[pos[lsq_pkg::IDX_W-1:0]].sq_tail;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      outstanding <= 1'b0;
      head_data_valid <= 1'b0;
    end else begin
      if (mem_req_valid && mem_req_ready) begin
        outstanding <= 1'b1;
      end else if (rsp_valid) begin
        outstanding <= 1'b0;
      end
      // A response that lands with the flush belongs to a squashed load.
      if (flush) begin
        head <= tail;
        head_data_valid <= 1'b0;
      end else begin
        if (alloc_valid) begin
          tail <= tail + 1'b1;
        end
        if (pop) begin
          head <= head + 1'b1;
          head_data_valid <= 1'b0;
        end else if (rsp_valid) begin
          head_data_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rsp_valid) begin
      head_data <= rsp_data;
    end
    if (alloc_valid) begin
      entries[tail[lsq_pkg::IDX_W-1:0]] <= alloc_entry;
    end
  end

  a_rsp_needs_read: assert property (
    @(posedge clock) disable iff (reset) rsp_valid |-> outstanding);

endmodule

`default_nettype wire

/* hw/lsq/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       commit_store,
  input  logic                       alloc_valid,
  input  lsq_pkg::store_entry_t      alloc_entry,
  output logic                       full,
  output logic [lsq_pkg::IDX_W:0]    tail_ptr,
  input  logic [mem_pkg::ADDR_W-1:0] fwd_addr,
  output lsq_pkg::fwd_t              fwd,
  input  logic                       barrier_valid,
  input  logic [lsq_pkg::IDX_W:0]    barrier_ptr,
  output logic                       mem_req_valid,
  output mem_pkg::mem_req_t          mem_req,
  input  logic                       mem_req_ready
);

  lsq_pkg::store_entry_t entries [lsq_pkg::LSQ_DEPTH];

  logic [lsq_pkg::IDX_W:0]   head;
  logic [lsq_pkg::IDX_W:0]   commit_ptr;
  logic [lsq_pkg::IDX_W:0]   tail;
  logic [lsq_pkg::IDX_W:0]   count;
  logic [lsq_pkg::IDX_W:0]   barrier_dist;
  logic [lsq_pkg::IDX_W-1:0] head_slot;
  logic                      head_before_barrier;
  logic                      drain;

  assign count = tail - head;
  assign full = count == (lsq_pkg::IDX_W + 1)'(lsq_pkg::LSQ_DEPTH);
  assign tail_ptr = tail;
  assign head_slot = head[lsq_pkg::IDX_W-1:0];

  // Stores at or past the barrier are younger than a load still waiting to read.
  assign barrier_dist = barrier_ptr - head;
  assign head_before_barrier = barrier_dist != '0 &&
                               barrier_dist <= (lsq_pkg::IDX_W + 1)'(lsq_pkg::LSQ_DEPTH);

  assign mem_req_valid = count != '0 && entries[head_slot].committed &&
                         (!barrier_valid || head_before_barrier);
  assign mem_req = '{write: 1'b1,
                     addr:  entries[head_slot].addr,
                     wdata: entries[head_slot].data};
  assign drain = mem_req_valid && mem_req_ready;

  // Walk from head to tail so the youngest match is the one that sticks.
  always_comb begin
    logic [lsq_pkg::IDX_W:0] offset;
    logic [lsq_pkg::IDX_W:0] pos;
    fwd = '0;
    for (int i = 0; i < lsq_pkg::LSQ_DEPTH; i++) begin
      offset = (lsq_pkg::IDX_W + 1)'(i);
      pos = head + offset;
      if (offset < count && entries[pos[lsq_pkg::IDX_W-1:0]].addr == fwd_addr) begin
        fwd.hit = 1'b1;
        fwd.data = entries[pos[lsq_pkg::IDX_W-1:0]].data;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      commit_ptr <= '0;
      tail <= '0;
    end else begin
      if (drain) begin
        head <= head + 1'b1;
      end
      if (commit_store) begin
        commit_ptr <= commit_ptr + 1'b1;
      end
      // Squashed stores are everything past the commit point.
      if (flush) begin
        tail <= commit_ptr;
      end else if (alloc_valid) begin
        tail <= tail + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc_valid) begin
      entries[tail[lsq_pkg::IDX_W-1:0]] <= alloc_entry;
    end
    if (commit_store) begin
      entries[commit_ptr[lsq_pkg::IDX_W-1:0]].committed <= 1'b1;
    end
  end

  a_no_alloc_when_full: assert property (
    @(posedge clock) disable iff (reset) alloc_valid |-> !full);

  a_commit_within_tail: assert property (
    @(posedge clock) disable iff (reset) commit_store |-> commit_ptr != tail);

endmodule

`default_nettype wire

/* hw/lsq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_top (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_valid,
  input  lsq_pkg::dispatch_t    dispatch,
  output logic                  dispatch_ready,
  input  logic                  commit_store,
  input  logic                  flush,
  output logic                  load_result_valid,
  output lsq_pkg::load_result_t load_result,
  input  logic                  load_result_ready
);

  logic                       is_load;
  logic                       sq_full;
  logic                       lq_full;
  logic                       sq_alloc;
  logic                       lq_alloc;
  logic [lsq_pkg::IDX_W:0]    sq_tail;
  lsq_pkg::fwd_t              fwd;
  lsq_pkg::store_entry_t      store_entry;
  lsq_pkg::load_entry_t       load_entry;
  logic                       barrier_valid;
  logic [lsq_pkg::IDX_W:0]    barrier_ptr;
  logic                       sq_req_valid;
  mem_pkg::mem_req_t          sq_req;
  logic                       sq_req_ready;
  logic                       lq_req_valid;
  mem_pkg::mem_req_t          lq_req;
  logic                       lq_req_ready;
  logic                       mem_valid;
  mem_pkg::mem_req_t          mem_req;
  logic                       mem_rsp_valid;
  logic [mem_pkg::DATA_W-1:0] mem_rsp_data;
  logic                       lq_rsp_valid;
  logic [mem_pkg::DATA_W-1:0] lq_rsp_data;

  assign is_load = dispatch.kind == lsq_pkg::OP_LOAD;
  assign dispatch_ready = !flush && (is_load ? !lq_full : !sq_full);
  assign sq_alloc = dispatch_valid && dispatch_ready && !is_load;
  assign lq_alloc = dispatch_valid && dispatch_ready && is_load;

  assign store_entry = '{addr: dispatch.addr, data: dispatch.data, committed: 1'b0};
  assign load_entry = '{tag:       dispatch.tag,
                        addr:      dispatch.addr,
                        forwarded: fwd.hit,
                        fwd_data:  fwd.data,
                        sq_tail:   sq_tail};

  store_queue i_store_queue (
    .clock, .reset, .flush, .commit_store,
    .alloc_valid(sq_alloc), .alloc_entry(store_entry), .full(sq_full),
    .tail_ptr(sq_tail), .fwd_addr(dispatch.addr), .fwd,
    .barrier_valid, .barrier_ptr,
    .mem_req_valid(sq_req_valid), .mem_req(sq_req), .mem_req_ready(sq_req_ready)
  );

  load_queue i_load_queue (
    .clock, .reset, .flush,
    .alloc_valid(lq_alloc), .alloc_entry(load_entry), .full(lq_full),
    .barrier_valid, .barrier_ptr,
    .mem_req_valid(lq_req_valid), .mem_req(lq_req), .mem_req_ready(lq_req_ready),
    .rsp_valid(lq_rsp_valid), .rsp_data(lq_rsp_data),
    .load_result_valid, .load_result, .load_result_ready
  );

  mem_arbiter i_mem_arbiter (
    .clock, .reset,
    .load_req_valid(lq_req_valid), .load_req(lq_req), .load_req_ready(lq_req_ready),
    .store_req_valid(sq_req_valid), .store_req(sq_req), .store_req_ready(sq_req_ready),
    .mem_valid, .mem_req, .mem_rsp_valid, .mem_rsp_data,
    .rsp_valid(lq_rsp_valid), .rsp_data(lq_rsp_data)
  );

  data_memory i_data_memory (
    .clock, .reset,
    .req_valid(mem_valid), .req(mem_req),
    .rsp_valid(mem_rsp_valid), .rsp_data(mem_rsp_data)
  );

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       load_req_valid,
  input  mem_pkg::mem_req_t          load_req,
  output logic                       load_req_ready,
  input  logic                       store_req_valid,
  input  mem_pkg::mem_req_t          store_req,
  output logic                       store_req_ready,
  output logic                       mem_valid,
  output mem_pkg::mem_req_t          mem_req,
  input  logic                       mem_rsp_valid,
  input  logic [mem_pkg::DATA_W-1:0] mem_rsp_data,
  output logic                       rsp_valid,
  output logic [mem_pkg::DATA_W-1:0] rsp_data
);

  // Set when the last grant went to the store queue.
  logic last_store;

  assign load_req_ready = load_req_valid && (!store_req_valid || last_store);
  assign store_req_ready = store_req_valid && (!load_req_valid || !last_store);

  assign mem_valid = load_req_ready || store_req_ready;
  assign mem_req = store_req_ready ? store_req : load_req;

  always_ff @(posedge clock) begin
    if (reset) begin
      last_store <= 1'b0;
    end else if (mem_valid) begin
      last_store <= store_req_ready;
    end
  end

  // Only reads answer, and only loads read.
  assign rsp_valid = mem_rsp_valid;
  assign rsp_data = mem_rsp_data;

  a_one_grant: assert property (
    @(posedge clock) disable iff (reset) !(load_req_ready && store_req_ready));

endmodule

`default_nettype wire

/* sim/lsq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsq_tb;

  localparam int SEED = 17316;
  localparam int DIRECTED_OPS = 40;
  localparam int RANDOM_OPS = 2000;
  localparam int TIMEOUT_CYCLES = 20 * (DIRECTED_OPS + RANDOM_OPS) + 500;

  logic                  clock;
  logic                  reset;
  logic                  dispatch_valid;
  lsq_pkg::dispatch_t    dispatch;
  logic                  dispatch_ready;
  logic                  commit_store;
  logic                  flush;
  logic                  load_result_valid;
  lsq_pkg::load_result_t load_result;
  logic                  load_result_ready;

  // Program-order history of accepted operations.
  lsq_pkg::dispatch_t    history [$];
  bit                    squashed [$];
  int                    pending_loads [$];
  int                    pending_stores [$];
  bit                    dispatch_taken;
  bit                    held_valid;
  lsq_pkg::load_result_t held_result;
  logic [lsq_pkg::TAG_W-1:0] next_tag;
  int                    results_seen;
  int                    cycle_count;
  int                    ops_done;

  lsq_top i_lsq_top (
    .clock, .reset, .dispatch_valid, .dispatch, .dispatch_ready,
    .commit_store, .flush, .load_result_valid, .load_result, .load_result_ready
  );

  always #2 clock = ~clock;

  task automatic fail_run();
    $display("** FAIL **");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("mismatch %s: got %h, expected %h", name, got, want);
      fail_run();
    end
  endtask

  task automatic check_load_result(input string name, input lsq_pkg::load_result_t got,
                                   input lsq_pkg::load_result_t want);
    if (got.tag !== want.tag) begin
      $display("mismatch %s.tag: got %h, expected %h", name, got.tag, want.tag);
      fail_run();
    end
    if (got.data !== want.data) begin
      $display("mismatch %s.data: got %h, expected %h", name, got.data, want.data);
      fail_run();
    end
  endtask

  // Latest surviving store before pos to the same address, else zero.
  function automatic logic [mem_pkg::DATA_W-1:0] expected_load(
      input logic [mem_pkg::ADDR_W-1:0] addr, input int pos);
    for (int i = pos - 1; i >= 0; i--) begin
      if (history[i].kind == lsq_pkg::OP_STORE && !squashed[i] && history[i].addr == addr) begin
        return history[i].data;
      end
    end
    return '0;
  endfunction

  // Few addresses, so stores and loads collide often.
  function automatic logic [mem_pkg::ADDR_W-1:0] pick_addr();
    case ($urandom_range(0, 3))
      0: return 8'h04;
      1: return 8'h05;
      2: return 8'h80;
      default: return 8'hff;
    endcase
  endfunction

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) step();
  endtask

  task automatic send_op(input lsq_pkg::op_kind_e kind, input logic [mem_pkg::ADDR_W-1:0] addr,
                         input logic [mem_pkg::DATA_W-1:0] data);
    dispatch_valid = 1'b1;
    dispatch = '{kind: kind, tag: next_tag, addr: addr, data: data};
    do begin
      step();
    end while (!dispatch_taken);
    dispatch_valid = 1'b0;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic pulse_commit();
    commit_store = 1'b1;
    step();
    commit_store = 1'b0;
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    step();
    flush = 1'b0;
  endtask

  task automatic wait_for_results();
    while (pending_loads.size() != 0) begin
      step();
    end
  endtask

  // Everything sampled here takes effect at the next rising edge.
  always @(negedge clock) begin
    lsq_pkg::load_result_t want;
    int pos;
    if (!reset) begin
      if (held_valid) begin
        check_flag("load_result_valid", load_result_valid, 1'b1);
        check_load_result("load_result", load_result, held_result);
      end
      if (load_result_valid && pending_loads.size() == 0) begin
        $display("a load result with tag %h appeared while no load was waiting", load_result.tag);
        fail_run();
      end
      if (load_result_valid && load_result_ready) begin
        pos = pending_loads.pop_front();
        want.tag = history[pos].tag;
        want.data = expected_load(history[pos].addr, pos);
        check_load_result("load_result", load_result, want);
        results_seen++;
      end
      dispatch_taken = dispatch_valid && dispatch_ready;
      if (dispatch_taken) begin
        history.push_back(dispatch);
        squashed.push_back(1'b0);
        if (dispatch.kind == lsq_pkg::OP_LOAD) begin
          pending_loads.push_back(history.size() - 1);
        end else begin
          pending_stores.push_back(history.size() - 1);
        end
      end
      if (commit_store) begin
        void'(pending_stores.pop_front());
      end
      if (flush) begin
        foreach (pending_stores[i]) begin
          squashed[pending_stores[i]] = 1'b1;
        end
        pending_stores.delete();
        pending_loads.delete();
      end
      held_valid = load_result_valid && !load_result_ready && !flush;
      held_result = load_result;
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, %0d loads never returned a result",
               cycle_count, pending_loads.size());
      fail_run();
    end
  end

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    dispatch_valid = 1'b0;
    dispatch = '{kind: lsq_pkg::OP_LOAD, tag: '0, addr: '0, data: '0};
    commit_store = 1'b0;
    flush = 1'b0;
    load_result_ready = 1'b1;
    next_tag = '0;
    results_seen = 0;
    cycle_count = 0;
    void'($urandom(SEED));
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    check_flag("dispatch_ready", dispatch_ready, 1'b1);
    check_flag("load_result_valid", load_result_valid, 1'b0);
    step();

    // Forwarding from undrained stores, youngest wins.
    send_op(lsq_pkg::OP_STORE, 8'h20, 32'ha1a1_0001);
    send_op(lsq_pkg::OP_STORE, 8'h20, 32'ha2a2_0002);
    send_op(lsq_pkg::OP_STORE, 8'h21, 32'hb0b0_0003);
    send_op(lsq_pkg::OP_LOAD, 8'h20, '0);
    send_op(lsq_pkg::OP_LOAD, 8'h21, '0);
    wait_for_results();

    // Untouched address, then reads through memory after the drain.
    repeat (3) pulse_commit();
    send_op(lsq_pkg::OP_LOAD, 8'h40, '0);
    idle(12);
    send_op(lsq_pkg::OP_LOAD, 8'h20, '0);
    send_op(lsq_pkg::OP_LOAD, 8'h21, '0);
    wait_for_results();

    // Flush while results are held.
    send_op(lsq_pkg::OP_STORE, 8'h30, 32'hc1c1_0004);
    pulse_commit();
    send_op(lsq_pkg::OP_STORE, 8'h30, 32'hc2c2_0005);
    send_op(lsq_pkg::OP_STORE, 8'h30, 32'hc3c3_0006);
    send_op(lsq_pkg::OP_STORE, 8'h50, 32'hd0d0_0007);
    load_result_ready = 1'b0;
    send_op(lsq_pkg::OP_LOAD, 8'h30, '0);
    send_op(lsq_pkg::OP_LOAD, 8'h50, '0);
    send_op(lsq_pkg::OP_LOAD, 8'h44, '0);
    idle(2);
    pulse_flush();
    load_result_ready = 1'b1;
    send_op(lsq_pkg::OP_LOAD, 8'h30, '0);
    send_op(lsq_pkg::OP_LOAD, 8'h50, '0);
    wait_for_results();

    // Eight waiting loads fill the load queue.
    load_result_ready = 1'b0;
    repeat (8) send_op(lsq_pkg::OP_LOAD, pick_addr(), '0);
    dispatch_valid = 1'b1;
    dispatch = '{kind: lsq_pkg::OP_LOAD, tag: next_tag, addr: pick_addr(), data: '0};
    repeat (4) begin
      @(negedge clock);
      check_flag("dispatch_ready", dispatch_ready, 1'b0);
      step();
    end
    load_result_ready = 1'b1;
    do begin
      step();
    end while (!dispatch_taken);
    dispatch_valid = 1'b0;
    next_tag = next_tag + 1'b1;
    wait_for_results();

    // Long random mix.
    ops_done = 0;
    while (ops_done < RANDOM_OPS) begin
      if (dispatch_valid && dispatch_taken) begin
        dispatch_valid = 1'b0;
        next_tag = next_tag + 1'b1;
        ops_done++;
      end
      if (!dispatch_valid && ops_done < RANDOM_OPS && $urandom_range(0, 3) != 0) begin
        dispatch_valid = 1'b1;
        dispatch.kind = ($urandom_range(0, 1) == 0) ? lsq_pkg::OP_LOAD : lsq_pkg::OP_STORE;
        dispatch.tag = next_tag;
        dispatch.addr = pick_addr();
        dispatch.data = $urandom();
      end
      commit_store = 1'b0;
      flush = 1'b0;
      if ($urandom_range(0, 99) < 2) begin
        flush = 1'b1;
      end else if (pending_stores.size() != 0 && $urandom_range(0, 99) < 30) begin
        commit_store = 1'b1;
      end
      if (load_result_ready ? $urandom_range(0, 9) == 0 : $urandom_range(0, 3) == 0) begin
        load_result_ready = !load_result_ready;
      end
      step();
    end
    dispatch_valid = 1'b0;
    commit_store = 1'b0;
    flush = 1'b0;
    load_result_ready = 1'b1;
    wait_for_results();
    idle(20);

    $display("%0d load results checked", results_seen);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
